//--- project.f
+incdir+.
policer_pkg.sv
ingress_arbiter.sv
traffic_policer.sv
drop_filter.sv
policer_top.sv
tb_policer_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the policer testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_policer_top -o sim_policer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_policer > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation log holds no result"
    exit 1
fi

exit 0

//--- tb_policer_top.sv
// policer testbench
// directed tests of packet merging, leaky-bucket marking and the drop filter
`timescale 1ns/1ps
`include "policer_defs.svh"

module tb_policer_top;
    import policer_pkg::*;

    localparam int NP = `POLICER_NUM_PORTS;
    localparam int DW = `POLICER_DATA_WIDTH;
    localparam int WAIT_LIMIT = 3000; // cycles

    logic             packet_in;
    logic             rst;
    logic [NP-1:0]    src_valid;
    logic [NP-1:0]    src_ready;
    logic [NP*DW-1:0] src_data;
    logic [NP-1:0]    src_last;
    logic [NP*16-1:0] src_length;
    logic [NP-1:0]    enable;
    logic [NP*16-1:0] decrement;
    logic [NP*16-1:0] threshold;
    logic             out_valid;
    logic             out_ready = 1'b1;
    data_t            out_data;
    logic             out_last;
    port_id_t         out_port;
    drop_count_t      drop_count;

    integer      seed = 32;
    logic        bp_on = 1'b0;  // random back-pressure on out_ready
    logic [34:0] exp_q[$];      // {port, last, data}
    logic [34:0] got_q[$];
    int          errors = 0;
    int          errors_before = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    initial begin
        packet_in = 1'b0;
        forever #20 packet_in = ~packet_in;
    end

    policer_top policer_top_i (
        .packet_in(packet_in), .rst(rst),
        .src_valid(src_valid), .src_ready(src_ready), .src_data(src_data),
        .src_last(src_last), .src_length(src_length),
        .enable(enable), .decrement(decrement), .threshold(threshold),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .out_last(out_last), .out_port(out_port), .drop_count(drop_count)
    );

    // beat transfers on the next rising edge, inputs are stable here
    always @(negedge packet_in) begin
        if (!rst && out_valid && out_ready) begin
            got_q.push_back({out_port, out_last, out_data});
        end
    end

    always @(posedge packet_in) begin
        out_ready <= bp_on ? 1'($random(seed) & 1) : 1'b1;
    end

    // bucket with no drain, fill in whole bytes
    function automatic bit bucket_admits(inout int fill, input int len, input int thr);
        if (fill + len > thr) begin
            return 1'b0;
        end
        fill = fill + len;
        return 1'b1;
    endfunction

    task automatic reset_with_config(input string name, input logic [NP-1:0] en,
                                     input logic [NP*16-1:0] dec,
                                     input logic [NP*16-1:0] thr);
        @(posedge packet_in);
        enable <= en;
        decrement <= dec;
        threshold <= thr;
        rst <= 1'b1;
        repeat (2) @(posedge packet_in);
        rst <= 1'b0;
        exp_q.delete();
        got_q.delete();
        errors_before = errors;
        @(negedge packet_in); // registers hold their reset values here
        if (src_ready != '0 || out_valid != 1'b0 || drop_count != '0) begin
            $display("Error: %s reset state expected ready 0 valid 0 count 0 actual %b %b %0d",
                     name, src_ready, out_valid, drop_count);
            errors++;
        end
    endtask

    task automatic send_packet(input int p, input int len, input bit pass);
        int          nbeats;
        int          tmo;
        logic [31:0] w;
        nbeats = (len + 3) / 4;
        @(posedge packet_in);
        for (int b = 0; b < nbeats; b++) begin
            w = $random(seed);
            src_valid[p] <= 1'b1;
            src_data[p*DW +: DW] <= w;
            src_last[p] <= (b == nbeats - 1);
            src_length[p*16 +: 16] <= 16'(len);
            if (pass) begin
                exp_q.push_back({2'(p), b == nbeats - 1, w});
            end
            tmo = 0;
            @(negedge packet_in);
            while (!src_ready[p] && tmo < WAIT_LIMIT) begin
                @(negedge packet_in);
                tmo++;
            end
            if (tmo >= WAIT_LIMIT) begin
                $display("source port %0d was never granted ready", p);
                errors++;
                @(posedge packet_in);
                src_valid[p] <= 1'b0;
                src_last[p] <= 1'b0;
                return;
            end
            @(posedge packet_in); // beat taken on this edge
        end
        src_valid[p] <= 1'b0;
        src_last[p] <= 1'b0;
    endtask

    task automatic send_random(input int p, input int n);
        int len;
        for (int k = 0; k < n; k++) begin
            len = ($random(seed) & 63) + 1;
            send_packet(p, len, 1'b1);
        end
    endtask

    // 100-byte packets against a non-draining bucket
    task automatic send_policed(input int p, input int n, input int thr, output int drops);
        int fill;
        bit pass;
        fill = 0;
        drops = 0;
        for (int k = 0; k < n; k++) begin
            pass = bucket_admits(fill, 100, thr);
            if (!pass) begin
                drops++;
            end
            send_packet(p, 100, pass);
        end
    endtask

    task automatic wait_output(input int exp_drops);
        int tmo;
        tmo = 0;
        while ((got_q.size() < exp_q.size() || drop_count != drop_count_t'(exp_drops))
               && tmo < WAIT_LIMIT) begin
            @(negedge packet_in);
            tmo++;
        end
        if (tmo >= WAIT_LIMIT) begin
            $display("output stream did not complete within %0d cycles", WAIT_LIMIT);
            errors++;
        end
    endtask

    // per-port order and content, then the drop counter
    task automatic finish_test(input string name, input int exp_drops);
        int j;
        int fails;
        wait_output(exp_drops);
        for (int p = 0; p < NP; p++) begin
            j = 0;
            foreach (exp_q[i]) begin
                if (exp_q[i][34:33] == 2'(p)) begin
                    while (j < got_q.size() && got_q[j][34:33] != 2'(p)) begin
                        j++;
                    end
                    if (j >= got_q.size()) begin
                        $display("%s: port %0d beat %h never came out", name, p, exp_q[i][31:0]);
                        errors++;
                    end else if (got_q[j] != exp_q[i]) begin
                        $display("Error: %s port %0d beat expected %h actual %h",
                                 name, p, exp_q[i], got_q[j]);
                        errors++;
                    end
                    j++;
                end
            end
        end
        if (got_q.size() != exp_q.size()) begin
            $display("Error: %s beat count expected %0d actual %0d",
                     name, exp_q.size(), got_q.size());
            errors++;
        end
        if (drop_count != drop_count_t'(exp_drops)) begin
            $display("Error: %s drop_count expected %0d actual %0d", name, exp_drops, drop_count);
            errors++;
        end
        fails = errors - errors_before;
        if (fails == 0) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, fails);
            tests_failed++;
        end
    endtask

    task automatic test_pass_through();
        reset_with_config("pass_through", '0, '0, '0);
        fork
            send_random(0, 3);
            send_random(1, 3);
            send_random(2, 3);
            send_random(3, 3);
        join
        finish_test("pass_through", 0);
    endtask

    task automatic test_threshold();
        int drops;
        reset_with_config("threshold", 4'b0010, '0, {16'd0, 16'd0, 16'd300, 16'd0});
        send_policed(1, 6, 300, drops);
        finish_test("threshold", drops);
    endtask

    // decrement 1.0 per cycle, so 100 bytes drain in 100 cycles
    task automatic test_drain();
        reset_with_config("drain", 4'b0100, {16'h0000, 16'h0100, 16'h0000, 16'h0000},
                          {16'd0, 16'd150, 16'd0, 16'd0});
        send_packet(2, 100, 1'b1);
        send_packet(2, 100, 1'b0); // bucket still near 70 here
        repeat (120) @(posedge packet_in);
        send_packet(2, 100, 1'b1);
        finish_test("drain", 1);
    endtask

    task automatic test_independence();
        int d0;
        int d3;
        reset_with_config("independence", 4'b1001, '0, {16'hffff, 16'd0, 16'd0, 16'd300});
        fork
            send_policed(0, 5, 300, d0);
            send_policed(3, 5, 65535, d3);
        join
        finish_test("independence", d0 + d3);
    endtask

    task automatic test_back_pressure();
        int d1;
        reset_with_config("back_pressure", 4'b0010, '0, {16'd0, 16'd0, 16'd300, 16'd0});
        bp_on = 1'b1;
        fork
            send_random(0, 4);
            send_policed(1, 5, 300, d1);
            send_random(2, 4);
            send_random(3, 4);
        join
        wait_output(d1);
        bp_on = 1'b0;
        finish_test("back_pressure", d1);
    endtask

    task automatic test_round_robin();
        reset_with_config("round_robin", '0, '0, '0);
        fork
            send_packet(0, 8, 1'b1);
            send_packet(1, 8, 1'b1);
            send_packet(2, 8, 1'b1);
            send_packet(3, 8, 1'b1);
        join
        wait_output(0);
        // two beats per packet, so packet k starts at entry 2k
        for (int k = 0; k < NP; k++) begin
            if (got_q.size() > 2 * k && got_q[2*k][34:33] != 2'(k)) begin
                $display("Error: round_robin packet %0d port expected %0d actual %0d",
                         k, k, got_q[2*k][34:33]);
                errors++;
            end
        end
        finish_test("round_robin", 0);
    endtask

    initial begin
        rst = 1'b1;
        src_valid = '0;
        src_data = '0;
        src_last = '0;
        src_length = '0;
        enable = '0;
        decrement = '0;
        threshold = '0;
        test_pass_through();
        test_threshold();
        test_drain();
        test_independence();
        test_back_pressure();
        test_round_robin();
        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- policer_top.sv
// policer top
// arbiter, leaky-bucket policer and drop filter in series
`timescale 1ns/1ps
`include "policer_defs.svh"

module policer_top (
    input  logic                                                          packet_in,
    input  logic                                                          rst,
    input  logic [`POLICER_NUM_PORTS-1:0]                                 src_valid,
    output logic [`POLICER_NUM_PORTS-1:0]                                 src_ready,
    input  logic [`POLICER_NUM_PORTS*`POLICER_DATA_WIDTH-1:0]             src_data,
    input  logic [`POLICER_NUM_PORTS-1:0]                                 src_last,
    input  logic [`POLICER_NUM_PORTS*$bits(policer_pkg::byte_len_t)-1:0]  src_length,
    input  logic [`POLICER_NUM_PORTS-1:0]                                 enable,
    input  logic [`POLICER_NUM_PORTS*$bits(policer_pkg::decrement_t)-1:0] decrement,
    input  logic [`POLICER_NUM_PORTS*$bits(policer_pkg::threshold_t)-1:0] threshold,
    output logic                                                          out_valid,
    input  logic                                                          out_ready,
    output policer_pkg::data_t                                            out_data,
    output logic                                                          out_last,
    output policer_pkg::port_id_t                                         out_port,
    output policer_pkg::drop_count_t                                      drop_count
);
    import policer_pkg::*;

    // arbiter to policer
    logic      arb_valid;
    logic      arb_ready;
    data_t     arb_data;
    logic      arb_last;
    byte_len_t arb_length;
    port_id_t  arb_port;

    // policer to filter
    logic      pol_valid;
    logic      pol_ready;
    data_t     pol_data;
    logic      pol_last;
    port_id_t  pol_port;
    logic      pol_drop;

    ingress_arbiter ingress_arbiter_i (
        .packet_in(packet_in), .rst(rst),
        .src_valid(src_valid), .src_ready(src_ready), .src_data(src_data),
        .src_last(src_last), .src_length(src_length),
        .arb_valid(arb_valid), .arb_ready(arb_ready), .arb_data(arb_data),
        .arb_last(arb_last), .arb_length(arb_length), .arb_port(arb_port)
    );

    traffic_policer traffic_policer_i (
        .packet_in(packet_in), .rst(rst),
        .enable(enable), .decrement(decrement), .threshold(threshold),
        .arb_valid(arb_valid), .arb_ready(arb_ready), .arb_data(arb_data),
        .arb_last(arb_last), .arb_length(arb_length), .arb_port(arb_port),
        .pol_valid(pol_valid), .pol_ready(pol_ready), .pol_data(pol_data),
        .pol_last(pol_last), .pol_port(pol_port), .pol_drop(pol_drop)
    );

    drop_filter drop_filter_i (
        .packet_in(packet_in), .rst(rst),
        .pol_valid(pol_valid), .pol_ready(pol_ready), .pol_data(pol_data),
        .pol_last(pol_last), .pol_port(pol_port), .pol_drop(pol_drop),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .out_last(out_last), .out_port(out_port), .drop_count(drop_count)
    );

endmodule

//--- drop_filter.sv
// drop filter
// discards packets carrying the drop mark and counts them
`timescale 1ns/1ps
`include "policer_defs.svh"

module drop_filter (
    input  logic                      packet_in,
    input  logic                      rst,
    input  logic                      pol_valid,
    output logic                      pol_ready,
    input  policer_pkg::data_t        pol_data,
    input  logic                      pol_last,
    input  policer_pkg::port_id_t     pol_port,
    input  logic                      pol_drop,
    output logic                      out_valid,
    input  logic                      out_ready,
    output policer_pkg::data_t        out_data,
    output logic                      out_last,
    output policer_pkg::port_id_t     out_port,
    output policer_pkg::drop_count_t  drop_count
);
    import policer_pkg::*;

    logic sop;
    logic discard;   // inside a marked packet
    logic beat_drop;
    logic xfer;

    assign beat_drop = sop ? pol_drop : discard;
    // dropped beats are eaten regardless of the downstream
    assign pol_ready = beat_drop || !out_valid || out_ready;
    assign xfer = pol_valid && pol_ready;

    always_ff @(posedge packet_in) begin
        if (rst) begin
            sop <= 1'b1;
            discard <= 1'b0;
            drop_count <= '0;
        end else if (xfer) begin
            sop <= pol_last;
            if (pol_last) begin
                discard <= 1'b0;
            end else if (sop && pol_drop) begin
                discard <= 1'b1;
            end
            if (sop && pol_drop) begin
                drop_count <= drop_count + drop_count_t'(1);
            end
        end
    end

    always_ff @(posedge packet_in) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (xfer && !beat_drop) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge packet_in) begin
        if (xfer && !beat_drop) begin
            out_data <= pol_data;
            out_last <= pol_last;
            out_port <= pol_port;
        end
    end

    // a beat loaded for output never carries the policer's mark
    a_no_marked_out: assert property (@(posedge packet_in) disable iff (rst)
        xfer && !beat_drop |-> !pol_drop);

endmodule

//--- traffic_policer.sv
// traffic policer
// one leaky bucket per ingress port, marks packets that overflow their bucket
`timescale 1ns/1ps
`include "policer_defs.svh"

module traffic_policer (
    input  logic                                                          packet_in,
    input  logic                                                          rst,
    input  logic [`POLICER_NUM_PORTS-1:0]                                 enable,
    input  logic [`POLICER_NUM_PORTS*$bits(policer_pkg::decrement_t)-1:0] decrement,
    input  logic [`POLICER_NUM_PORTS*$bits(policer_pkg::threshold_t)-1:0] threshold,
    input  logic                                                          arb_valid,
    output logic                                                          arb_ready,
    input  policer_pkg::data_t                                            arb_data,
    input  logic                                                          arb_last,
    input  policer_pkg::byte_len_t                                        arb_length,
    input  policer_pkg::port_id_t                                         arb_port,
    output logic                                                          pol_valid,
    input  logic                                                          pol_ready,
    output policer_pkg::data_t                                            pol_data,
    output logic                                                          pol_last,
    output policer_pkg::port_id_t                                         pol_port,
    output logic                                                          pol_drop
);
    import policer_pkg::*;

    localparam int NP = `POLICER_NUM_PORTS;
    localparam int FB = `POLICER_FRAC_BITS;
    localparam int BW = $bits(bucket_t);
    localparam int DEC_W = $bits(decrement_t);
    localparam int TW = $bits(threshold_t);

    bucket_t           bucket [NP];
    bucket_t           dec_ext [NP];   // drain widened to the bucket format
    logic              sop;            // next accepted beat opens a packet
    logic              accept;
    logic              drop_hold;      // mark of the packet in progress
    bucket_t           cur_bucket;
    threshold_t        cur_thr;
    logic [TW:0]       fill_check;
    logic              mark_now;
    bucket_t           fill_sum;
    bucket_t           fill_next;
    logic [NP-1:0]     admit;
    logic              pol_mid;
    logic              mid_drop;

    assign arb_ready = !pol_valid || pol_ready;
    assign accept = arb_valid && arb_ready;

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            dec_ext[p] = bucket_t'(decrement[p*DEC_W +: DEC_W]);
        end
    end

    // check against the bucket of the incoming packet's port
    assign cur_bucket = bucket[arb_port];
    assign cur_thr = threshold[arb_port*TW +: TW];
    assign fill_check = {1'b0, cur_bucket[BW-1:FB]} + {1'b0, arb_length};
    assign mark_now = enable[arb_port] && (fill_check > {1'b0, cur_thr});

    // fits in BW bits once the threshold check has passed
    assign fill_sum = cur_bucket + (bucket_t'(arb_length) << FB);
    assign fill_next = (fill_sum > dec_ext[arb_port]) ? fill_sum - dec_ext[arb_port] : '0;

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            admit[p] = accept && sop && enable[p] && !mark_now && (arb_port == port_id_t'(p));
        end
    end

    always_ff @(posedge packet_in) begin
        if (rst) begin
            for (int p = 0; p < NP; p++) begin
                bucket[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NP; p++) begin
                if (admit[p]) begin
                    bucket[p] <= fill_next;
                end else if (enable[p] && bucket[p] > dec_ext[p]) begin
                    bucket[p] <= bucket[p] - dec_ext[p];
                end else begin
                    bucket[p] <= '0; // drained out or port off
                end
            end
        end
    end

    always_ff @(posedge packet_in) begin
        if (rst) begin
            sop <= 1'b1;
            drop_hold <= 1'b0;
        end else if (accept) begin
            sop <= arb_last;
            if (sop) begin
                drop_hold <= mark_now;
            end
        end
    end

    // register stage carrying the mark
    always_ff @(posedge packet_in) begin
        if (rst) begin
            pol_valid <= 1'b0;
        end else if (accept) begin
            pol_valid <= 1'b1;
        end else if (pol_ready) begin
            pol_valid <= 1'b0;
        end
    end

    always_ff @(posedge packet_in) begin
        if (accept) begin
            pol_data <= arb_data;
            pol_last <= arb_last;
            pol_port <= arb_port;
            pol_drop <= sop ? mark_now : drop_hold;
        end
    end

    // output side packet tracking
    always_ff @(posedge packet_in) begin
        if (rst) begin
            pol_mid <= 1'b0;
            mid_drop <= 1'b0;
        end else if (pol_valid && pol_ready) begin
            pol_mid <= !pol_last;
            mid_drop <= pol_drop;
        end
    end

    a_drop_stable: assert property (@(posedge packet_in) disable iff (rst)
        pol_valid && pol_mid |-> pol_drop == mid_drop);

    // an admitted packet leaves its bucket at or under the limit, so no wrap
    for (genvar p = 0; p < NP; p++) begin : g_bucket_chk
        a_no_wrap: assert property (@(posedge packet_in) disable iff (rst)
            admit[p] |=> bucket[p][BW-1:FB] <= $past(threshold[p*TW +: TW]));
    end

endmodule

//--- ingress_arbiter.sv
// ingress arbiter
// round-robin merge of the source streams, one whole packet per grant
`timescale 1ns/1ps
`include "policer_defs.svh"

module ingress_arbiter (
    input  logic                                                         packet_in,
    input  logic                                                         rst,
    input  logic [`POLICER_NUM_PORTS-1:0]                                src_valid,
    output logic [`POLICER_NUM_PORTS-1:0]                                src_ready,
    input  logic [`POLICER_NUM_PORTS*`POLICER_DATA_WIDTH-1:0]            src_data,
    input  logic [`POLICER_NUM_PORTS-1:0]                                src_last,
    input  logic [`POLICER_NUM_PORTS*$bits(policer_pkg::byte_len_t)-1:0] src_length,
    output logic                                                         arb_valid,
    input  logic                                                         arb_ready,
    output policer_pkg::data_t                                           arb_data,
    output logic                                                         arb_last,
    output policer_pkg::byte_len_t                                       arb_length,
    output policer_pkg::port_id_t                                        arb_port
);
    import policer_pkg::*;

    localparam int NP = `POLICER_NUM_PORTS;
    localparam int DW = `POLICER_DATA_WIDTH;
    localparam int LW = $bits(byte_len_t);

    arb_state_t state;
    port_id_t   grant;
    port_id_t   last_grant;
    port_id_t   next_port;
    logic       found;
    logic       out_free;
    logic       accept;
    logic       mid_packet; // output register is inside a packet
    port_id_t   packet_port;

    // search starts just after the previous winner
    always_comb begin
        port_id_t cand;
        next_port = last_grant;
        found = 1'b0;
        for (int i = 1; i <= NP; i++) begin
            cand = port_id_t'((int'(last_grant) + i) % NP);
            if (!found && src_valid[cand]) begin
                next_port = cand;
                found = 1'b1;
            end
        end
    end

    assign out_free = !arb_valid || arb_ready; // empty or draining this cycle

    always_comb begin
        src_ready = '0;
        if (state == forward && out_free) begin
            src_ready[grant] = 1'b1;
        end
    end

    assign accept = src_valid[grant] && src_ready[grant];

    always_ff @(posedge packet_in) begin
        if (rst) begin
            state <= idle;
            grant <= '0;
            last_grant <= port_id_t'(NP - 1); // so port 0 wins first
        end else begin
            case (state)
                idle: begin
                    if (found) begin
                        grant <= next_port;
                        state <= forward;
                    end
                end
                forward: begin
                    if (accept && src_last[grant]) begin
                        last_grant <= grant;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // output stage
    always_ff @(posedge packet_in) begin
        if (rst) begin
            arb_valid <= 1'b0;
        end else if (accept) begin
            arb_valid <= 1'b1;
        end else if (arb_ready) begin
            arb_valid <= 1'b0;
        end
    end

    always_ff @(posedge packet_in) begin
        if (accept) begin
            arb_data   <= src_data[grant*DW +: DW];
            arb_last   <= src_last[grant];
            arb_length <= src_length[grant*LW +: LW];
            arb_port   <= grant;
        end
    end

    // tracks the tag of the packet in flight on the output
    always_ff @(posedge packet_in) begin
        if (rst) begin
            mid_packet <= 1'b0;
            packet_port <= '0;
        end else if (arb_valid && arb_ready) begin
            mid_packet <= !arb_last;
            packet_port <= arb_port;
        end
    end

    a_port_stable: assert property (@(posedge packet_in) disable iff (rst)
        arb_valid && mid_packet |-> arb_port == packet_port);

    a_valid_hold: assert property (@(posedge packet_in) disable iff (rst)
        arb_valid && !arb_ready |=> arb_valid && $stable(arb_data) && $stable(arb_port));

endmodule

//--- policer_pkg.sv
// policer types
// width typedefs and the arbiter FSM encoding
`include "policer_defs.svh"

package policer_pkg;

    // one beat of packet payload
    typedef logic [`POLICER_DATA_WIDTH-1:0] data_t;

    // sideband byte length, valid on the first beat
    typedef logic [15:0] byte_len_t;

    // ingress port tag
    typedef logic [$clog2(`POLICER_NUM_PORTS)-1:0] port_id_t;

    // bucket fill, 16 whole bits over the fraction
    typedef logic [16+`POLICER_FRAC_BITS-1:0] bucket_t;

    // per-cycle drain, 8 whole bits over the fraction
    typedef logic [8+`POLICER_FRAC_BITS-1:0] decrement_t;

    // bucket limit in whole bytes
    typedef logic [15:0] threshold_t;

    // dropped packet counter, wraps
    typedef logic [15:0] drop_count_t;

    // arbiter: waiting for a request, or holding a grant
    typedef enum logic {
        idle,
        forward
    } arb_state_t;

endpackage

//--- policer_defs.svh
// policer build constants
// port count, beat width and fixed-point split shared by all stages
`ifndef POLICER_DEFS_SVH
`define POLICER_DEFS_SVH

// ingress streams merged by the arbiter
`define POLICER_NUM_PORTS 4

// one beat is a 32-bit word, four bytes
`define POLICER_DATA_WIDTH 32

// fraction bits of the bucket and of the drain amount
// bucket is 16.8 and decrement is 8.8, so both line up on this split
`define POLICER_FRAC_BITS 8

`endif
